//--- hw/cacc_align.sv
/* stage 1: product exponent scaling, alignment of both
   mantissas to the larger exponent, cut bits of the smaller one */
`timescale 1ns/1ps

module cacc_align (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   in_valid,
  input  logic                   in_sel,
  input  logic [43:0]            in_data,
  input  cacc_pkg::partial_t     op,
  output cacc_pkg::align_stage_t align
);

  import cacc_pkg::*;

  data_expo_t            d_expn;
  data_mant_t            d_mant_pre;
  logic [DATA_LSD_W-1:0] d_mant;
  logic [DATA_LSD_W-1:0] d_manm;
  lead_cnt_t             d_lead;
  logic                  d_zero;
  logic                  o_zero;
  op_expo_t              d_expm;
  op_expo_t              d_expo;
  op_expo_t              o_expo;
  op_expo_t              max_expo;
  op_expo_t              d_shift_n;
  op_expo_t              o_shift_n;
  op_mant_t              d_ext;
  logic [2*ALIGN_W-1:0]  d_shift_all;
  logic [2*ALIGN_W-1:0]  o_shift_all;
  op_mant_t              d_aligned;
  op_mant_t              o_aligned;
  cut_t                  d_cut;
  cut_t                  o_cut;
  cut_t                  cut_nxt;
  logic                  vld_q;
  logic                  sel_q;
  op_mant_t              d_mant_q;
  op_mant_t              o_mant_q;
  cut_t                  cut_q;
  op_expo_t              expo_q;

  // ====================
  // product split
  // ====================
  assign d_expn     = in_data[43:38];
  assign d_mant_pre = in_data[37:0];
  // top three bits are sign copies, search only the low 36
  assign d_mant     = d_mant_pre[DATA_LSD_W-1:0];
  assign d_zero     = ~(|d_mant_pre);
  assign o_zero     = ~(|op.mant);

  cacc_lsd #(.LSD_W(DATA_LSD_W)) u_lsd (.a(d_mant), .enc(d_lead));

  // normalize product, exponent onto the 63 bias
  assign d_expm = op_expo_t'(d_expn) + op_expo_t'(DATA_EXPO_OFFSET) - op_expo_t'(d_lead);
  assign d_manm = d_mant << d_lead;
  assign d_expo = d_zero ? '0 : d_expm;
  assign o_expo = o_zero ? '0 : op.expo;

  // ====================
  // align to max exponent
  // ====================
  assign max_expo  = (d_expo > o_expo) ? d_expo : o_expo;
  assign d_shift_n = max_expo - d_expo;
  assign o_shift_n = max_expo - o_expo;
  // four zero bits below the product mantissa
  assign d_ext     = {d_manm, 4'b0};

  // upper half is the aligned value, lower half the bits cut off
  assign d_shift_all = $signed({d_ext, {ALIGN_W{1'b0}}}) >>> d_shift_n;
  assign o_shift_all = $signed({op.mant, {ALIGN_W{1'b0}}}) >>> o_shift_n;

  // far shifts saturate to sign fill
  assign d_aligned = (d_shift_n >= ALIGN_W) ? {ALIGN_W{d_ext[ALIGN_W-1]}}
                                            : d_shift_all[2*ALIGN_W-1:ALIGN_W];
  assign o_aligned = (o_shift_n >= ALIGN_W) ? {ALIGN_W{op.mant[ALIGN_W-1]}}
                                            : o_shift_all[2*ALIGN_W-1:ALIGN_W];

  // guard, round, then or of the rest
  assign d_cut   = {d_shift_all[ALIGN_W-1:ALIGN_W-2], |d_shift_all[ALIGN_W-3:0]};
  assign o_cut   = {o_shift_all[ALIGN_W-1:ALIGN_W-2], |o_shift_all[ALIGN_W-3:0]};
  // only the smaller operand loses bits
  assign cut_nxt = (d_expo > o_expo) ? o_cut : (d_expo < o_expo) ? d_cut : '0;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      vld_q <= 1'b0;
      sel_q <= 1'b0;
    end else begin
      vld_q <= in_valid;
      sel_q <= in_valid & in_sel;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (in_valid) begin
      d_mant_q <= d_aligned;
      o_mant_q <= o_aligned;
      cut_q    <= cut_nxt;
      expo_q   <= max_expo;
    end
  end

  assign align.vld       = vld_q;
  assign align.sel       = sel_q;
  assign align.data_mant = d_mant_q;
  assign align.op_mant   = o_mant_q;
  assign align.cut       = cut_q;
  assign align.expo      = expo_q;

endmodule

//--- hw/cacc_calc_fp48.sv
/* fp48 partial sum pipeline top, operand mask and stage chain */
`timescale 1ns/1ps

module cacc_calc_fp48 (
  input  logic               nvdla_core_clk,
  input  logic               nvdla_core_rstn,
  input  logic [43:0]        in_data,
  input  cacc_pkg::partial_t in_op,
  input  logic               in_op_valid,
  input  logic               in_sel,
  input  logic               in_valid,
  output cacc_pkg::fp32_t    out_final_data,
  output logic               out_final_valid,
  output cacc_pkg::partial_t out_partial_data,
  output logic               out_partial_valid
);

  import cacc_pkg::*;

  partial_t     op_masked;
  align_stage_t align;
  sum_stage_t   msum;
  logic         final_pending;

  // no stored sum yet means add to zero
  assign op_masked = in_op_valid ? in_op : '0;

  // ====================
  // stage chain
  // ====================
  cacc_align u_align (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_valid        (in_valid),
    .in_sel          (in_sel),
    .in_data         (in_data),
    .op              (op_masked),
    .align           (align)
  );

  cacc_sum_nmlz u_sum_nmlz (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .align           (align),
    .msum            (msum)
  );

  // partial sum register also feeds the fp32 stage
  cacc_round u_round (
    .nvdla_core_clk    (nvdla_core_clk),
    .nvdla_core_rstn   (nvdla_core_rstn),
    .msum              (msum),
    .out_partial_data  (out_partial_data),
    .out_partial_valid (out_partial_valid),
    .final_pending     (final_pending)
  );

  cacc_fp32_cvt u_fp32_cvt (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .partial         (out_partial_data),
    .final_pending   (final_pending),
    .out_final_data  (out_final_data),
    .out_final_valid (out_final_valid)
  );

endmodule

//--- hw/cacc_fp32_cvt.sv
/* stage 4: partial sum to sign-magnitude, 24 bit round
   and rebias into the registered fp32 word */
`timescale 1ns/1ps

module cacc_fp32_cvt (
  input  logic               nvdla_core_clk,
  input  logic               nvdla_core_rstn,
  input  cacc_pkg::partial_t partial,
  input  logic               final_pending,
  output cacc_pkg::fp32_t    out_final_data,
  output logic               out_final_valid
);

  import cacc_pkg::*;

  logic        p_sign;
  logic [38:0] p_umant;
  logic        p_neg2;
  logic        p_zero;
  logic [38:0] mant_abs;
  logic [23:0] mant_effect;
  logic        point5;
  logic        mant_carry;
  logic [24:0] mant_round;
  logic [22:0] mant_nmlz;
  op_expo_t    expo_round;
  op_expo_t    expo_nmlz;
  fp32_t       fp32_result;

  assign p_sign  = partial.mant[ALIGN_W-1];
  assign p_umant = partial.mant[ALIGN_W-2:0];
  // exactly -2, magnitude overflows the 39 bits
  assign p_neg2  = p_sign & ~(|p_umant);
  assign p_zero  = ~(|partial.mant);

  // ====================
  // magnitude and round
  // ====================
  assign mant_abs    = p_sign ? (~p_umant + 39'd1) : p_umant;
  assign mant_effect = mant_abs[38:15];
  assign point5      = mant_abs[14];
  assign mant_carry  = (&mant_effect) & point5;
  assign mant_round  = {1'b0, mant_effect} + {24'b0, point5};
  // hidden bit dropped, carry shifts right
  assign mant_nmlz   = mant_carry ? mant_round[23:1] : mant_round[22:0];

  // rebias, plus one for carry or the -2 case
  assign expo_round  = partial.expo + op_expo_t'(FP32_EXPO_OFFSET)
                     + op_expo_t'(mant_carry | p_neg2);
  assign expo_nmlz   = p_zero ? '0 : expo_round;
  assign fp32_result = {p_sign, expo_nmlz, mant_nmlz};

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_final_valid <= 1'b0;
    end else begin
      out_final_valid <= final_pending;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (final_pending) begin
      out_final_data <= fp32_result;
    end
  end

endmodule

//--- hw/cacc_lsd.sv
/* leading sign detector, returns the count of redundant sign bits */
`timescale 1ns/1ps

module cacc_lsd #(
  parameter int LSD_W = 36
) (
  input  logic [LSD_W-1:0]    a,
  output cacc_pkg::lead_cnt_t enc
);

  import cacc_pkg::*;

  // priority search from msb-1 down
  // the last hit in the loop is the highest differing bit
  always_comb begin
    // all bits equal to the sign
    enc = lead_cnt_t'(LSD_W - 1);
    for (int i = 0; i < LSD_W - 1; i++) begin
      if (a[i] != a[LSD_W-1]) begin
        enc = lead_cnt_t'(LSD_W - 2 - i);
      end
    end
  end

endmodule

//--- hw/cacc_pkg.sv
/* cacc package with width typedefs, format constants
   and the structs passed between pipeline stages */
package cacc_pkg;

  // ====================
  // widths
  // ====================
  // product operand, bias 30, mantissa not normalized
  typedef logic [5:0]  data_expo_t;
  typedef logic [37:0] data_mant_t;
  // partial sum operand, bias 63, mantissa normalized
  typedef logic [7:0]  op_expo_t;
  typedef logic [39:0] op_mant_t;
  // guard, round, sticky of the shifted-out operand
  typedef logic [2:0]  cut_t;
  // normalized sum, then guard and sticky
  typedef logic [41:0] msum_t;
  typedef logic [5:0]  lead_cnt_t;
  typedef logic [31:0] fp32_t;

  // ====================
  // format constants
  // ====================
  // rebias 30 to 63 plus the binary point move of the product
  localparam int DATA_EXPO_OFFSET = 47;
  // rebias 63 to 127
  localparam int FP32_EXPO_OFFSET = 64;
  localparam int ALIGN_W          = 40;
  // 41 bit sum with the 3 cut bits below
  localparam int SUM_LSD_W        = 44;
  // product mantissa without its two top sign copies
  localparam int DATA_LSD_W       = 36;

  // ====================
  // stage structs
  // ====================
  typedef struct packed {
    logic     vld;
    logic     sel;
    op_mant_t data_mant;
    op_mant_t op_mant;
    cut_t     cut;
    op_expo_t expo;
  } align_stage_t;

  typedef struct packed {
    logic     vld;
    logic     sel;
    op_expo_t expo;
    msum_t    msum;
  } sum_stage_t;

  // also the layout of the partial sum ports
  typedef struct packed {
    op_expo_t expo;
    op_mant_t mant;
  } partial_t;

endpackage

//--- hw/cacc_round.sv
/* stage 3: round to nearest, carry renormalize,
   partial sum register and final pending flag */
`timescale 1ns/1ps

module cacc_round (
  input  logic                 nvdla_core_clk,
  input  logic                 nvdla_core_rstn,
  input  cacc_pkg::sum_stage_t msum,
  output cacc_pkg::partial_t   out_partial_data,
  output logic                 out_partial_valid,
  output logic                 final_pending
);

  import cacc_pkg::*;

  logic             sum_sign;
  op_mant_t         sum_effect;
  logic             sum_guard;
  logic             sum_stick;
  logic             point5;
  logic [ALIGN_W:0] sum_round;
  logic             carry_pos;
  logic             carry_neg;
  logic [ALIGN_W:0] nmlz_tmp;
  op_mant_t         mant_nmlz;
  logic             mant_zero;
  op_expo_t         expo_nmlz;
  op_expo_t         expo_nxt;
  op_expo_t         expo_q;
  op_mant_t         mant_q;

  assign sum_sign   = msum.msum[41];
  assign sum_effect = msum.msum[41:2];
  assign sum_guard  = msum.msum[1];
  assign sum_stick  = msum.msum[0];

  // ====================
  // round
  // ====================
  // ties go up for positive values only
  assign point5    = sum_guard & (~sum_sign | sum_stick);
  assign sum_round = {sum_sign, sum_effect} + {{ALIGN_W{1'b0}}, point5};

  // 01.111..1 rounds into 10.000..0
  assign carry_pos = ~sum_sign & (&sum_effect[ALIGN_W-2:0]) & point5;
  // 10.111..1 rounds into 11.000..0, one redundant sign
  assign carry_neg = sum_sign & ~sum_effect[ALIGN_W-2] & (&sum_effect[ALIGN_W-3:0]) & point5;

  assign nmlz_tmp  = carry_neg ? {sum_round[ALIGN_W-1:0], 1'b0}
                   : carry_pos ? {sum_round[ALIGN_W], sum_round[ALIGN_W:1]}
                   : sum_round;
  assign mant_nmlz = nmlz_tmp[ALIGN_W-1:0];
  assign mant_zero = ~(|mant_nmlz);

  assign expo_nmlz = carry_neg ? (msum.expo - 8'd1) : (msum.expo + op_expo_t'(carry_pos));
  // zero keeps a clean exponent
  assign expo_nxt  = mant_zero ? '0 : expo_nmlz;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_partial_valid <= 1'b0;
      final_pending     <= 1'b0;
    end else begin
      out_partial_valid <= msum.vld & ~msum.sel;
      final_pending     <= msum.vld & msum.sel;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (msum.vld) begin
      expo_q <= expo_nxt;
      mant_q <= mant_nmlz;
    end
  end

  assign out_partial_data.expo = expo_q;
  assign out_partial_data.mant = mant_q;

endmodule

//--- hw/cacc_sum_nmlz.sv
/* stage 2: add of the aligned mantissas, normalize by
   leading sign count, tail folded into guard and sticky */
`timescale 1ns/1ps

module cacc_sum_nmlz (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  cacc_pkg::align_stage_t align,
  output cacc_pkg::sum_stage_t   msum
);

  import cacc_pkg::*;

  logic [ALIGN_W:0]          mant_sum;
  logic [SUM_LSD_W-1:0]      sum_total;
  lead_cnt_t                 lead;
  op_expo_t                  expo_nrml;
  logic signed [SUM_LSD_W:0] sum_comp;
  logic signed [SUM_LSD_W:0] sum_scmp;
  msum_t                     sum_ncmp;
  logic                      vld_q;
  logic                      sel_q;
  op_expo_t                  expo_q;
  msum_t                     msum_q;

  // ====================
  // add
  // ====================
  // one extra bit for the carry
  assign mant_sum  = {align.data_mant[ALIGN_W-1], align.data_mant}
                   + {align.op_mant[ALIGN_W-1], align.op_mant};
  assign sum_total = {mant_sum, align.cut};

  cacc_lsd #(.LSD_W(SUM_LSD_W)) u_lsd (.a(sum_total), .enc(lead));

  // ====================
  // normalize
  // ====================
  // sum carries one int bit more than the aligned format
  assign expo_nrml = align.expo + 8'd1 - op_expo_t'(lead);

  // spare zero at the bottom so a carry can shift right
  assign sum_comp = {sum_total, 1'b0};
  assign sum_scmp = (|lead) ? (sum_comp <<< (lead - 6'd1)) : (sum_comp >>> 1);
  // 41 kept bits, low three into sticky
  assign sum_ncmp = {sum_scmp[SUM_LSD_W-1:3], |sum_scmp[2:0]};

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      vld_q <= 1'b0;
      sel_q <= 1'b0;
    end else begin
      vld_q <= align.vld;
      sel_q <= align.vld & align.sel;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (align.vld) begin
      expo_q <= expo_nrml;
      msum_q <= sum_ncmp;
    end
  end

  assign msum.vld  = vld_q;
  assign msum.sel  = sel_q;
  assign msum.expo = expo_q;
  assign msum.msum = msum_q;

endmodule

//--- list.f
+incdir+test
hw/cacc_pkg.sv
hw/cacc_lsd.sv
hw/cacc_align.sv
hw/cacc_sum_nmlz.sv
hw/cacc_round.sv
hw/cacc_fp32_cvt.sv
hw/cacc_calc_fp48.sv
test/tb_cacc_calc_fp48.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the cacc_calc_fp48 testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_cacc_calc_fp48 \
  -f list.f

# the simulation status is judged from the log below
./obj_dir/Vtb_cacc_calc_fp48 > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
  exit 1
fi
if ! grep -q "Everything OK" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

//--- test/cacc_ref_model.svh
/* reference model of the fp48 partial sum step
   and of the fp32 conversion, bit exact */
`ifndef CACC_REF_MODEL_SVH
`define CACC_REF_MODEL_SVH

// number of copies of the sign below the msb of a w bit value
function automatic int sign_run(logic [63:0] v, int w);
  int n;
  n = 0;
  for (int i = w - 2; i >= 0; i--) begin
    if (v[i] == v[w-1] && n == w - 2 - i) n++;
  end
  return n;
endfunction

// product {expo6, mant38} plus stored sum {expo8, mant40}
function automatic logic [47:0] model_partial(logic [43:0] data, logic [47:0] op);
  logic [35:0] dm;
  int          dn;
  int          ds;
  int          os;
  int          sn;
  logic [7:0]  dexp;
  logic [7:0]  oexp;
  logic [7:0]  mexp;
  logic [7:0]  e;
  logic [39:0] dx;
  logic [39:0] ox;
  logic [39:0] da;
  logic [39:0] oa;
  logic [39:0] eff;
  logic [39:0] m;
  logic [79:0] dw;
  logic [79:0] ow;
  logic [2:0]  cut;
  logic [40:0] s;
  logic [40:0] r;
  logic [43:0] tot;
  logic [43:0] t;
  logic        up;
  // product onto the bias 63 scale
  dm   = data[35:0];
  dn   = sign_run(64'(dm), 36);
  dx   = {dm << dn, 4'b0};
  dexp = (data[37:0] == '0) ? 8'd0 : 8'(int'(data[43:38]) + 47 - dn);
  ox   = op[39:0];
  oexp = (ox == '0) ? 8'd0 : op[47:40];
  mexp = (dexp > oexp) ? dexp : oexp;
  ds   = int'(mexp) - int'(dexp);
  os   = int'(mexp) - int'(oexp);
  // low 40 bits hold what fell off the right end
  dw   = $signed({dx, 40'b0}) >>> ds;
  ow   = $signed({ox, 40'b0}) >>> os;
  da   = (ds >= 40) ? {40{dx[39]}} : dw[79:40];
  oa   = (os >= 40) ? {40{ox[39]}} : ow[79:40];
  if (dexp > oexp) cut = {ow[39:38], |ow[37:0]};
  else if (dexp < oexp) cut = {dw[39:38], |dw[37:0]};
  else cut = 3'b0;
  // add, then sign to the top
  s    = {da[39], da} + {oa[39], oa};
  tot  = {s, cut};
  sn   = sign_run(64'(tot), 44);
  e    = 8'(int'(mexp) + 1 - sn);
  t    = tot << sn;
  eff  = t[43:4];
  // nearest, ties up only when positive
  up   = t[3] & (~eff[39] | (|t[2:0]));
  r    = {eff[39], eff} + 41'(up);
  if (r[40] != r[39]) begin
    m = r[40:1];
    e = e + 8'd1;
  end else if (up && eff[39] && !eff[38] && r[38]) begin
    m = {r[38:0], 1'b0};
    e = e - 8'd1;
  end else begin
    m = r[39:0];
  end
  if (m == '0) e = 8'd0;
  return {e, m};
endfunction

// partial sum to ieee single
function automatic logic [31:0] model_fp32(logic [47:0] p);
  logic        sign;
  logic [38:0] u;
  logic [38:0] mag;
  logic [24:0] rnd;
  logic [22:0] frac;
  logic [7:0]  e;
  sign = p[39];
  u    = p[38:0];
  mag  = sign ? (39'd0 - u) : u;
  rnd  = {1'b0, mag[38:15]} + 25'(mag[14]);
  frac = rnd[24] ? rnd[23:1] : rnd[22:0];
  e    = p[47:40] + 8'd64 + 8'(rnd[24] || (sign && u == '0));
  if (p[39:0] == '0) e = 8'd0;
  return {sign, e, frac};
endfunction

`endif

//--- test/tb_cacc_calc_fp48.sv
/* testbench for cacc_calc_fp48 with random and directed beats
   checked against the reference model at fixed latency */
`timescale 1ns/1ps

module tb_cacc_calc_fp48;

  import cacc_pkg::*;

  `include "cacc_ref_model.svh"

  localparam int RESET_CYCLES = 4;
  localparam int IDLE_CYCLES  = 3;
  localparam int NUM_DIRECTED = 10;
  localparam int NUM_RANDOM   = 400;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + IDLE_CYCLES + NUM_DIRECTED + NUM_RANDOM + 20;

  logic        nvdla_core_clk;
  logic        nvdla_core_rstn;
  logic [43:0] in_data;
  partial_t    in_op;
  logic        in_op_valid;
  logic        in_sel;
  logic        in_valid;
  fp32_t       out_final_data;
  logic        out_final_valid;
  partial_t    out_partial_data;
  logic        out_partial_valid;

  int          cyc;
  int          fail_count;
  integer      seed;
  // expected results with the cycle they are due
  int          part_due_q[$];
  logic [47:0] part_val_q[$];
  int          final_due_q[$];
  logic [31:0] final_val_q[$];

  cacc_calc_fp48 dut0 (
    .nvdla_core_clk    (nvdla_core_clk),
    .nvdla_core_rstn   (nvdla_core_rstn),
    .in_data           (in_data),
    .in_op             (in_op),
    .in_op_valid       (in_op_valid),
    .in_sel            (in_sel),
    .in_valid          (in_valid),
    .out_final_data    (out_final_data),
    .out_final_valid   (out_final_valid),
    .out_partial_data  (out_partial_data),
    .out_partial_valid (out_partial_valid)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #50 nvdla_core_clk = ~nvdla_core_clk;
  end

  task automatic fail_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(logic [63:0] actual, logic [63:0] expected, string what);
    if (actual !== expected) begin
      fail_count++;
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, actual, expected);
      fail_run();
    end
  endtask

  // ====================
  // cycle count and watchdog
  // ====================
  always @(posedge nvdla_core_clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYCLE_LIMIT) begin
      $display("timeout: results still pending after %0d cycles", cyc);
      fail_run();
    end
  end

  // outputs sampled on the falling edge once settled
  always @(negedge nvdla_core_clk) begin
    logic exp_pv;
    logic exp_fv;
    exp_pv = (part_due_q.size() > 0) && (part_due_q[0] == cyc);
    exp_fv = (final_due_q.size() > 0) && (final_due_q[0] == cyc);
    check_value(64'(out_partial_valid), 64'(exp_pv), "out_partial_valid");
    check_value(64'(out_final_valid), 64'(exp_fv), "out_final_valid");
    if (exp_pv) begin
      check_value(64'(out_partial_data), 64'(part_val_q[0]), "out_partial_data");
      void'(part_due_q.pop_front());
      void'(part_val_q.pop_front());
    end
    if (exp_fv) begin
      check_value(64'(out_final_data), 64'(final_val_q[0]), "out_final_data");
      void'(final_due_q.pop_front());
      void'(final_val_q.pop_front());
    end
  end

  // ====================
  // stimulus
  // ====================
  task automatic drive_beat(logic [43:0] data, logic [47:0] op, logic opv, logic sel);
    logic [47:0] p;
    @(posedge nvdla_core_clk);
    #1;
    in_data     = data;
    in_op       = op;
    in_op_valid = opv;
    in_sel      = sel;
    in_valid    = 1'b1;
    p = model_partial(data, opv ? op : 48'd0);
    if (sel) begin
      final_due_q.push_back(cyc + 4);
      final_val_q.push_back(model_fp32(p));
    end else begin
      part_due_q.push_back(cyc + 3);
      part_val_q.push_back(p);
    end
  endtask

  task automatic drive_idle();
    @(posedge nvdla_core_clk);
    #1;
    in_valid = 1'b0;
    in_sel   = 1'b0;
  endtask

  // top three mantissa bits equal, exponent never all ones
  function automatic logic [43:0] random_product();
    logic [35:0] m;
    logic [5:0]  e;
    m = 36'({$random(seed), $random(seed)});
    m = $signed(m) >>> ({$random(seed)} % 36);
    if (({$random(seed)} % 16) == 0) m = '0;
    e = 6'({$random(seed)} % 63);
    return {e, m[35], m[35], m};
  endfunction

  // normalized stored sum or zero
  function automatic logic [47:0] random_op();
    logic [39:0] m;
    logic [7:0]  e;
    m = 40'({$random(seed), $random(seed)});
    m[38] = ~m[39];
    if (({$random(seed)} % 2) == 0) e = 8'(40 + {$random(seed)} % 60);
    else e = 8'({$random(seed)} % 255);
    if (({$random(seed)} % 8) == 0) return 48'd0;
    return {e, m};
  endfunction

  initial begin
    seed            = 32'h6cd7e35f;
    cyc             = 0;
    fail_count      = 0;
    nvdla_core_rstn = 1'b0;
    in_data         = '0;
    in_op           = '0;
    in_op_valid     = 1'b0;
    in_sel          = 1'b0;
    in_valid        = 1'b0;
    repeat (RESET_CYCLES) @(posedge nvdla_core_clk);
    #1;
    nvdla_core_rstn = 1'b1;
    // valids must stay low while nothing is driven
    repeat (IDLE_CYCLES) drive_idle();

    // rounding corners
    drive_beat({6'd0, 38'd1}, {8'd52, 40'h7F_FFFF_FFFF}, 1'b1, 1'b0);
    drive_beat({6'd0, 38'd1}, {8'd52, 40'h7F_FFFF_FFFF}, 1'b1, 1'b1);
    // product lands in guard and round only, 10.111..1 rounds up
    drive_beat({6'd0, 38'd3}, {8'd53, 40'hBF_FFFF_FFFF}, 1'b1, 1'b0);
    drive_beat(44'd0, {8'd70, 40'h80_0000_0000}, 1'b1, 1'b0);
    drive_beat(44'd0, {8'd70, 40'h80_0000_0000}, 1'b1, 1'b1);
    // fp32 round carries out of 24 ones
    drive_beat(44'd0, {8'd60, 40'h7F_FFFF_C000}, 1'b1, 1'b1);
    // exact cancel
    drive_beat({6'd10, 2'b00, 36'h5_5555_5555}, {8'd57, 40'hAA_AAAA_AAB0}, 1'b1, 1'b0);
    drive_beat({6'd10, 2'b00, 36'h5_5555_5555}, {8'd57, 40'hAA_AAAA_AAB0}, 1'b1, 1'b1);
    // zero product, masked stored sum
    drive_beat({6'd20, 38'd0}, {8'd90, 40'h4A_BCDE_F012}, 1'b1, 1'b0);
    drive_beat({6'd25, 38'h00_1234_5678}, {8'd90, 40'h4A_BCDE_F012}, 1'b0, 1'b0);

    // random mix of mostly back to back beats
    for (int i = 0; i < NUM_RANDOM; i++) begin
      if (({$random(seed)} % 8) == 0) begin
        drive_idle();
      end else begin
        drive_beat(random_product(), random_op(), ({$random(seed)} % 8) != 0,
                   1'($random(seed)));
      end
    end

    while (part_due_q.size() > 0 || final_due_q.size() > 0) drive_idle();
    drive_idle();
    if (fail_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      fail_run();
    end
  end

endmodule
